// ==== tb/beam_pick_trace.txt ====
# C rows : capture four bursts of that many rows | X : replay, random indices and header
# R idx0..idx15 header lane0_of_first_row : replay | P rows header : pass-through frame
P 3 0123456789abcdef
C 5
R 0 1 2 3 4 5 6 7 8 9 10 11 12 13 14 15 a5a5000011112222 1000000000
R 63 17 17 32 5 48 0 15 31 47 16 33 2 62 63 1 5a5a3c3c0f0f9999 130000000f
P 4 fedcba9876543210
C 7
R 40 40 3 19 35 51 60 12 28 44 8 8 24 56 63 0 1122334455667788 2200000008
X
P 2 cafef00dcafef00d
C 1
R 20 5 50 35 20 5 50 35 0 63 16 47 32 31 48 15 0badc0de0badc0de 3100000004
X
P 1 0000000000000001

// ==== list.f ====
common/beam_geom_pkg.sv
common/beam_stream_pkg.sv
common/replay_seq_if.sv
beam_store/beam_store_write.sv
beam_store/beam_store_read.sv
beam_store/beam_bank_ram.sv
src/beam_select.sv
src/beam_out_mux.sv
src/beam_pick_top.sv
tb/tb_beam_pick.sv

// ==== Bender.yml ====
package:
  name: beam_pick

sources:
  - files:
      - common/beam_geom_pkg.sv
      - common/beam_stream_pkg.sv
      - common/replay_seq_if.sv
      - beam_store/beam_store_write.sv
      - beam_store/beam_store_read.sv
      - beam_store/beam_bank_ram.sv
      - src/beam_select.sv
      - src/beam_out_mux.sv
      - src/beam_pick_top.sv
  - target: test
    files:
      - tb/tb_beam_pick.sv

// ==== tb/tb_beam_pick.sv ====
// Run from the project root so the trace path resolves; ADDR_WIDTH 4 limits bursts to 16 rows
`default_nettype none

module tb_beam_pick;
    timeunit 1ns;
    timeprecision 1ps;
    import beam_geom_pkg::*;
    import beam_stream_pkg::*;

    localparam int AW         = 4;
    localparam int WAIT_LIMIT = 64;

    logic      i_clk;
    logic      i_reset;
    logic      i_wr_valid;
    logic      i_wr_sop;
    logic      i_wr_eop;
    beam_row_t i_wr_data;
    logic      i_sym_first;
    logic      i_sort_sop;
    sort_idx_t i_sort_idx;
    hdr_t      i_info;
    logic      o_valid;
    logic      o_sop;
    logic      o_eop;
    beam_row_t o_data;
    hdr_t      o_info;

    // Reference copy of the four captured bursts
    beam_row_t model [NUM_BANKS][1 << AW];
    int        cap_rows;
    int        gen;
    int        errors;
    int        tests;
    int        failed;

    beam_pick_top #(.ADDR_WIDTH(AW)) dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // --------------------
    // Helpers
    // --------------------
    // Sample word is tag, source, row, lane
    function automatic beam_row_t make_row(input logic [3:0] tag, input logic [3:0] src,
                                           input int r);
        beam_row_t row;
        for (int l = 0; l < NUM_BEAMS; l++)
            row[l] = {tag, src, 16'(r), 16'(l)};
        return row;
    endfunction

    function automatic hdr_t rand_hdr();
        return {$urandom, $urandom};
    endfunction

    task automatic check_bits(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_row(input string name, input beam_row_t got, input beam_row_t exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Problem at %0t: %s", $time, msg);
    endtask

    task automatic close_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("Test %0d, %s: ok", tests, name);
        end else begin
            failed++;
            $display("Test %0d, %s: FAILED", tests, name);
        end
    endtask

    // --------------------
    // Test steps
    // --------------------
    task automatic watch_idle();
        int errs_before;
        errs_before = errors;
        for (int c = 0; c < 20; c++) begin
            @(negedge i_clk);
            check_bits("o_valid", o_valid, 0);
            check_bits("o_sop", o_sop, 0);
            check_bits("o_eop", o_eop, 0);
        end
        close_test("idle after reset", errs_before);
    endtask

    task automatic capture_bursts(input int len);
        int errs_before;
        errs_before = errors;
        gen++;
        cap_rows = len;
        @(posedge i_clk);
        i_sym_first <= 1'b1;
        @(posedge i_clk);
        i_sym_first <= 1'b0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < len; r++) begin
                model[b][r] = make_row(gen[3:0], b[3:0], r);
                @(posedge i_clk);
                i_wr_valid <= 1'b1;
                i_wr_sop   <= (r == 0);
                i_wr_eop   <= (r == len - 1);
                i_wr_data  <= model[b][r];
                i_info     <= rand_hdr();
                @(negedge i_clk);
                check_bits("o_valid", o_valid, 0);
            end
            // One idle cycle between bursts
            @(posedge i_clk);
            i_wr_valid <= 1'b0;
            i_wr_sop   <= 1'b0;
            i_wr_eop   <= 1'b0;
            @(negedge i_clk);
            check_bits("o_valid", o_valid, 0);
        end
        close_test($sformatf("capture of 4 bursts, %0d rows", len), errs_before);
    endtask

    task automatic replay_frame(input string name, input sort_idx_t idx, input hdr_t hdr,
                                input logic [39:0] spot, input logic has_spot);
        int        errs_before;
        int        lat;
        beam_row_t exp_row;
        errs_before = errors;
        lat = 0;
        @(posedge i_clk);
        i_sort_sop <= 1'b1;
        i_sort_idx <= idx;
        i_info     <= hdr;
        for (int k = 1; k <= WAIT_LIMIT; k++) begin
            @(posedge i_clk);
            i_sort_sop <= 1'b0;
            i_info     <= rand_hdr();
            @(negedge i_clk);
            if (o_valid) begin
                lat = k;
                break;
            end
        end
        if (lat == 0) begin
            report_problem("replay output never became valid");
        end else begin
            check_bits("o_valid latency", lat, 3);
            for (int r = 0; r < cap_rows; r++) begin
                if (r > 0) begin
                    @(posedge i_clk);
                    i_info <= rand_hdr();
                    @(negedge i_clk);
                end
                // Lane j takes bank idx/16, lane idx mod 16
                for (int j = 0; j < NUM_BEAMS; j++)
                    exp_row[j] = model[idx[j] / NUM_BEAMS][r][idx[j] % NUM_BEAMS];
                check_bits("o_valid", o_valid, 1);
                check_bits("o_sop", o_sop, r == 0);
                check_bits("o_eop", o_eop, r == cap_rows - 1);
                check_row("o_data", o_data, exp_row);
                check_bits("o_info", o_info, hdr);
                if (has_spot && r == 0)
                    check_bits("o_data lane 0", o_data[0], spot);
            end
            @(posedge i_clk);
            @(negedge i_clk);
            check_bits("o_valid", o_valid, 0);
        end
        close_test(name, errs_before);
    endtask

    task automatic pass_frame(input int len, input hdr_t hdr);
        int errs_before;
        errs_before = errors;
        for (int r = 0; r <= len; r++) begin
            @(posedge i_clk);
            i_wr_valid <= (r < len);
            i_wr_sop   <= (r == 0);
            i_wr_eop   <= (r == len - 1);
            i_wr_data  <= make_row(4'hf, 4'he, r);
            i_info     <= hdr ^ 64'(r);
            @(negedge i_clk);
            // Row r-1 shows one cycle after it was driven
            if (r > 0) begin
                check_bits("o_valid", o_valid, 1);
                check_bits("o_sop", o_sop, r == 1);
                check_bits("o_eop", o_eop, r == len);
                check_row("o_data", o_data, make_row(4'hf, 4'he, r - 1));
                check_bits("o_info", o_info, hdr ^ 64'(r - 1));
            end
        end
        @(posedge i_clk);
        i_wr_sop <= 1'b0;
        i_wr_eop <= 1'b0;
        @(negedge i_clk);
        check_bits("o_valid", o_valid, 0);
        close_test($sformatf("pass-through of %0d rows", len), errs_before);
    endtask

    // --------------------
    // Trace runner
    // --------------------
    initial begin
        int              fd;
        int              code;
        int              len;
        int              val;
        logic [7:0]      kind;
        logic            done;
        logic [1023:0]   line_buf;
        sort_idx_t       idx;
        hdr_t            hdr;
        logic [39:0]     spot;
        i_reset     = 1'b1;
        i_wr_valid  = 1'b0;
        i_wr_sop    = 1'b0;
        i_wr_eop    = 1'b0;
        i_wr_data   = '0;
        i_sym_first = 1'b0;
        i_sort_sop  = 1'b0;
        i_sort_idx  = '0;
        i_info      = '0;
        errors      = 0;
        tests       = 0;
        failed      = 0;
        gen         = 0;
        cap_rows    = 0;
        void'($urandom(32'h9bbc_1339));
        repeat (16) @(posedge i_clk);
        i_reset <= 1'b0;
        watch_idle();

        fd = $fopen("tb/beam_pick_trace.txt", "r");
        if (fd == 0) begin
            report_problem("could not open the trace file");
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) begin
                    done = 1'b1;
                end else begin
                    case (kind)
                        "#": code = $fgets(line_buf, fd);
                        "C": begin
                            code = $fscanf(fd, "%d", len);
                            capture_bursts(len);
                        end
                        "R": begin
                            for (int j = 0; j < NUM_BEAMS; j++) begin
                                code = $fscanf(fd, "%d", val);
                                idx[j] = val[CAND_IDX_W-1:0];
                            end
                            code = $fscanf(fd, "%h %h", hdr, spot);
                            replay_frame("replay with trace indices", idx, hdr, spot, 1'b1);
                        end
                        "X": begin
                            for (int j = 0; j < NUM_BEAMS; j++)
                                idx[j] = CAND_IDX_W'($urandom % NUM_CAND);
                            replay_frame("replay with random indices", idx, rand_hdr(), '0,
                                         1'b0);
                        end
                        "P": begin
                            code = $fscanf(fd, "%d %h", len, hdr);
                            pass_frame(len, hdr);
                        end
                        default: begin
                            report_problem("unknown line kind in the trace file");
                            done = 1'b1;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0 && failed == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/beam_pick_top.sv ====
// No back-pressure on any path; ADDR_WIDTH must cover the longest burst in rows
`default_nettype none

module beam_pick_top #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_wr_valid,
    input  logic                      i_wr_sop,
    input  logic                      i_wr_eop,
    input  beam_geom_pkg::beam_row_t  i_wr_data,
    input  logic                      i_sym_first,
    input  logic                      i_sort_sop,
    input  beam_geom_pkg::sort_idx_t  i_sort_idx,
    input  beam_stream_pkg::hdr_t     i_info,
    output logic                      o_valid,
    output logic                      o_sop,
    output logic                      o_eop,
    output beam_geom_pkg::beam_row_t  o_data,
    output beam_stream_pkg::hdr_t     o_info
);
    import beam_geom_pkg::*;
    import beam_stream_pkg::*;

    logic [NUM_BANKS-1:0]  bank_wen;
    logic [ADDR_WIDTH-1:0] wr_addr;
    beam_row_t             wr_data;
    logic                  capture;
    logic [ADDR_WIDTH:0]   row_count;
    logic                  replay_done;
    sort_idx_t             sort_idx_q;
    hdr_t                  hdr_q;
    cand_row_t             cand;
    beam_row_t             sel_row;

    replay_seq_if #(.ADDR_WIDTH(ADDR_WIDTH)) seq ();

    beam_store_write #(.ADDR_WIDTH(ADDR_WIDTH)) u_write (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_wr_valid    (i_wr_valid),
        .i_wr_sop      (i_wr_sop),
        .i_wr_eop      (i_wr_eop),
        .i_wr_data     (i_wr_data),
        .i_sym_first   (i_sym_first),
        .i_replay_done (replay_done),
        .o_bank_wen    (bank_wen),
        .o_wr_addr     (wr_addr),
        .o_wr_data     (wr_data),
        .o_capture     (capture),
        .o_row_count   (row_count)
    );

    beam_store_read #(.ADDR_WIDTH(ADDR_WIDTH)) u_read (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_sort_sop    (i_sort_sop),
        .i_sort_idx    (i_sort_idx),
        .i_info        (i_info),
        .i_row_count   (row_count),
        .rd            (seq.reader),
        .o_sort_idx    (sort_idx_q),
        .o_hdr         (hdr_q),
        .o_replay_done (replay_done)
    );

    // Bank k feeds candidates 16k..16k+15
    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        beam_bank_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_bank (
            .i_clk     (i_clk),
            .i_wen     (bank_wen[k]),
            .i_wr_addr (wr_addr),
            .i_wr_data (wr_data),
            .rd        (seq.bank),
            .o_rd_data (cand[k*NUM_BEAMS +: NUM_BEAMS])
        );
    end

    beam_select u_select (
        .i_clk      (i_clk),
        .i_cand     (cand),
        .i_sort_idx (sort_idx_q),
        .o_row      (sel_row)
    );

    beam_out_mux u_out (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_capture  (capture),
        .rd         (seq.sink),
        .i_sel_row  (sel_row),
        .i_hdr      (hdr_q),
        .i_wr_valid (i_wr_valid),
        .i_wr_sop   (i_wr_sop),
        .i_wr_eop   (i_wr_eop),
        .i_wr_data  (i_wr_data),
        .i_info     (i_info),
        .o_valid    (o_valid),
        .o_sop      (o_sop),
        .o_eop      (o_eop),
        .o_data     (o_data),
        .o_info     (o_info)
    );

endmodule

`default_nettype wire

// ==== src/beam_out_mux.sv ====
// Replay rows win over input rows; input rows that arrive while replay rows are leaving are lost
`default_nettype none

module beam_out_mux (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_capture,
    replay_seq_if.sink                rd,
    input  beam_geom_pkg::beam_row_t  i_sel_row,
    input  beam_stream_pkg::hdr_t     i_hdr,
    input  logic                      i_wr_valid,
    input  logic                      i_wr_sop,
    input  logic                      i_wr_eop,
    input  beam_geom_pkg::beam_row_t  i_wr_data,
    input  beam_stream_pkg::hdr_t     i_info,
    output logic                      o_valid,
    output logic                      o_sop,
    output logic                      o_eop,
    output beam_geom_pkg::beam_row_t  o_data,
    output beam_stream_pkg::hdr_t     o_info
);
    import beam_geom_pkg::*;
    import beam_stream_pkg::*;

    frame_t    seq_q;
    frame_t    out_q;
    logic      rep_q;
    beam_row_t data_q;
    hdr_t      info_q;

    // --------------------
    // Read sequence delay
    // --------------------
    // First stage matches the bank read, the output register matches the selector
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            seq_q <= '0;
        end else begin
            seq_q.valid <= rd.rd_en;
            seq_q.sop   <= rd.rd_en && rd.rd_first;
            seq_q.eop   <= rd.rd_en && rd.rd_last;
        end
    end

    // --------------------
    // Output framing
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            out_q <= '0;
            rep_q <= 1'b0;
        end else if (seq_q.valid) begin
            out_q <= seq_q;
            rep_q <= 1'b1;
        end else if (i_capture) begin
            // Capture bursts are stored, not forwarded
            out_q <= '0;
            rep_q <= 1'b0;
        end else begin
            out_q.valid <= i_wr_valid;
            out_q.sop   <= i_wr_sop;
            out_q.eop   <= i_wr_eop;
            rep_q       <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        data_q <= i_wr_data;
        info_q <= seq_q.valid ? i_hdr : i_info;
    end

    // Selector output already sits at the right cycle
    assign o_data  = rep_q ? i_sel_row : data_q;
    assign o_info  = info_q;
    assign o_valid = out_q.valid;
    assign o_sop   = out_q.sop;
    assign o_eop   = out_q.eop;

    a_frame_in_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_sop || o_eop) |-> o_valid);

endmodule

`default_nettype wire

// ==== src/beam_select.sv ====
// Index must stay stable for the cycle before each selected row is registered
`default_nettype none

module beam_select (
    input  logic                      i_clk,
    input  beam_geom_pkg::cand_row_t  i_cand,
    input  beam_geom_pkg::sort_idx_t  i_sort_idx,
    output beam_geom_pkg::beam_row_t  o_row
);
    import beam_geom_pkg::*;

    // --------------------
    // Lane crossbar
    // --------------------
    // Candidate c lives in bank c/16, lane c%16; the cand row layout makes that a plain index
    always_ff @(posedge i_clk) begin
        for (int j = 0; j < NUM_BEAMS; j++) begin
            o_row[j] <= i_cand[i_sort_idx[j]];
        end
    end

endmodule

`default_nettype wire

// ==== beam_store/beam_bank_ram.sv ====
// Read data holds while rd_en is low; a read and write to one address returns the old data
`default_nettype none

module beam_bank_ram #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                      i_clk,
    input  logic                      i_wen,
    input  logic [ADDR_WIDTH-1:0]     i_wr_addr,
    input  beam_geom_pkg::beam_row_t  i_wr_data,
    replay_seq_if.bank                rd,
    output beam_geom_pkg::beam_row_t  o_rd_data
);
    import beam_geom_pkg::*;

    localparam int DEPTH = 1 << ADDR_WIDTH;

    beam_row_t mem [DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_wen)
            mem[i_wr_addr] <= i_wr_data;
    end

    // One-cycle registered read
    always_ff @(posedge i_clk) begin
        if (rd.rd_en)
            o_rd_data <= mem[rd.rd_addr];
    end

endmodule

`default_nettype wire

// ==== beam_store/beam_store_read.sv ====
// A new i_sort_sop must wait until the last row of the previous sweep; row count 0 is unsupported
`default_nettype none

module beam_store_read #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_sort_sop,
    input  beam_geom_pkg::sort_idx_t  i_sort_idx,
    input  beam_stream_pkg::hdr_t     i_info,
    input  logic [ADDR_WIDTH:0]       i_row_count,
    replay_seq_if.reader              rd,
    output beam_geom_pkg::sort_idx_t  o_sort_idx,
    output beam_stream_pkg::hdr_t     o_hdr,
    output logic                      o_replay_done
);

    // --------------------
    // Address sweep
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd.rd_en    <= 1'b0;
            rd.rd_addr  <= '0;
            rd.rd_first <= 1'b0;
            rd.rd_last  <= 1'b0;
        end else if (i_sort_sop) begin
            rd.rd_en    <= 1'b1;
            rd.rd_addr  <= '0;
            rd.rd_first <= 1'b1;
            rd.rd_last  <= (i_row_count == 1);
        end else if (rd.rd_en) begin
            if (rd.rd_last) begin
                rd.rd_en    <= 1'b0;
                rd.rd_first <= 1'b0;
                rd.rd_last  <= 1'b0;
            end else begin
                rd.rd_addr  <= rd.rd_addr + 1'b1;
                rd.rd_first <= 1'b0;
                // Next address is the last one
                rd.rd_last  <= ({1'b0, rd.rd_addr} + 2'd2 == i_row_count);
            end
        end
    end

    // Index and header stay put for the whole frame
    always_ff @(posedge i_clk) begin
        if (i_sort_sop) begin
            o_sort_idx <= i_sort_idx;
            o_hdr      <= i_info;
        end
    end

    assign o_replay_done = rd.rd_en && rd.rd_last;

    a_no_overlap: assert property (@(posedge i_clk) disable iff (i_reset)
        i_sort_sop |-> !rd.rd_en);

endmodule

`default_nettype wire

// ==== beam_store/beam_store_write.sv ====
// Bursts must be gap-free and all four the same length; rows after the fourth eop are dropped
`default_nettype none

module beam_store_write #(
    parameter int ADDR_WIDTH = 11
) (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  logic                                   i_wr_valid,
    input  logic                                   i_wr_sop,
    input  logic                                   i_wr_eop,
    input  beam_geom_pkg::beam_row_t               i_wr_data,
    input  logic                                   i_sym_first,
    input  logic                                   i_replay_done,
    output logic [beam_geom_pkg::NUM_BANKS-1:0]    o_bank_wen,
    output logic [ADDR_WIDTH-1:0]                  o_wr_addr,
    output beam_geom_pkg::beam_row_t               o_wr_data,
    output logic                                   o_capture,
    output logic [ADDR_WIDTH:0]                    o_row_count
);
    import beam_geom_pkg::*;

    // One extra bit so the counter can park at NUM_BANKS
    logic [BANK_SEL_W:0]   burst_cnt;
    logic [ADDR_WIDTH-1:0] addr_cnt;
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic                  accept;

    assign accept = o_capture && i_wr_valid && (burst_cnt < NUM_BANKS);

    // A sop always lands at row 0
    assign wr_ptr = i_wr_sop ? '0 : addr_cnt;

    // --------------------
    // Capture state
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_capture   <= 1'b0;
            burst_cnt   <= '0;
            addr_cnt    <= '0;
            o_row_count <= '0;
        end else if (i_sym_first) begin
            // Re-arm for a fresh set of four bursts
            o_capture <= 1'b1;
            burst_cnt <= '0;
            addr_cnt  <= '0;
        end else begin
            if (i_replay_done)
                o_capture <= 1'b0;
            if (accept) begin
                addr_cnt <= i_wr_eop ? '0 : wr_ptr + 1'b1;
                if (i_wr_eop) begin
                    burst_cnt <= burst_cnt + 1'b1;
                    if (burst_cnt == NUM_BANKS - 1)
                        o_row_count <= {1'b0, wr_ptr} + 1'b1;
                end
            end
        end
    end

    // --------------------
    // Bank write port
    // --------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_bank_wen <= '0;
        end else begin
            o_bank_wen <= '0;
            if (accept)
                o_bank_wen[burst_cnt[BANK_SEL_W-1:0]] <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wr_addr <= wr_ptr;
        o_wr_data <= i_wr_data;
    end

    // Every burst opens with sop at row 0
    a_sop_first: assert property (@(posedge i_clk) disable iff (i_reset)
        (accept && (addr_cnt == '0)) |-> i_wr_sop);

endmodule

`default_nettype wire

// ==== common/replay_seq_if.sv ====
// Replay read sequence; rd_first and rd_last mean nothing unless rd_en is high in the same cycle
`default_nettype none

interface replay_seq_if #(
    parameter int ADDR_WIDTH = 11
) ();

    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic                  rd_first;
    logic                  rd_last;

    modport reader (output rd_en, output rd_addr, output rd_first, output rd_last);
    modport bank   (input rd_en, input rd_addr);
    modport sink   (input rd_en, input rd_addr, input rd_first, input rd_last);

endinterface

`default_nettype wire

// ==== common/beam_stream_pkg.sv ====
// Stream sideband only; there is no ready signal, so every consumer must accept each valid cycle
`default_nettype none

package beam_stream_pkg;

    // IQ header word that travels with each row
    typedef logic [63:0] hdr_t;

    // Row framing
    typedef struct packed {
        logic valid;
        logic sop;
        logic eop;
    } frame_t;

endpackage

`default_nettype wire

// ==== common/beam_geom_pkg.sv ====
// Sizes are fixed at 16 beams per row and 4 banks; the index and bank widths follow from them
`default_nettype none

package beam_geom_pkg;

    // --------------------
    // Row geometry
    // --------------------
    localparam int NUM_BEAMS  = 16;
    localparam int NUM_BANKS  = 4;
    localparam int NUM_CAND   = NUM_BEAMS * NUM_BANKS;
    localparam int SAMPLE_W   = 40;

    // Index widths
    localparam int CAND_IDX_W = $clog2(NUM_CAND);
    localparam int BANK_SEL_W = $clog2(NUM_BANKS);

    // --------------------
    // Row and index types
    // --------------------
    // One stored or output row, lane 0 in the low bits
    typedef logic [NUM_BEAMS-1:0][SAMPLE_W-1:0] beam_row_t;

    // All four bank outputs side by side, bank k at lanes 16k..16k+15
    typedef logic [NUM_CAND-1:0][SAMPLE_W-1:0] cand_row_t;

    // Per output lane, which candidate to take
    typedef logic [NUM_BEAMS-1:0][CAND_IDX_W-1:0] sort_idx_t;

endpackage

`default_nettype wire
